// ==== logic/cfg_regs.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module cfg_regs import drbe_pkg::*; (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [`WB_AW-1:0]  wb_adr,
	input  logic [`WB_DW-1:0]  wb_dat_w,
	output logic [`WB_DW-1:0]  wb_dat_r,
	output logic               wb_ack,
	input  logic               scenario_update,
	output delay_t             delay [`N_CTRL],
	output dest_t              dest [`N_CTRL]
);

	localparam int NODE_W = $clog2(`N_CTRL);
	localparam int DW = `WB_DW;

	logic              req;
	logic [NODE_W-1:0] sel;
	delay_t            shadow_delay [`N_CTRL];
	dest_t             shadow_dest [`N_CTRL];

	// the ack edge ends the request so it is served once
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign sel = wb_adr[NODE_W:1];

	////////////////////////////////////////////////////////////
	// shadow and active registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			for (int n = 0; n < `N_CTRL; n++) begin
				shadow_delay[n] <= '0;
				shadow_dest[n] <= '0;
				delay[n] <= '0;
				dest[n] <= '0;
			end
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				if (wb_adr[0])
					shadow_dest[sel] <= wb_dat_w[`DEST_W-1:0];
				else
					shadow_delay[sel] <= wb_dat_w[`BUF_AW-1:0];
			end
			// all nodes switch scenario on the same edge
			if (scenario_update) begin
				for (int n = 0; n < `N_CTRL; n++) begin
					delay[n] <= shadow_delay[n];
					dest[n] <= shadow_dest[n];
				end
			end
		end
	end

	// read data is valid while wb_ack is high
	always_ff @(posedge CLK) begin
		if (req)
			wb_dat_r <= wb_adr[0] ? DW'(shadow_dest[sel]) : DW'(shadow_delay[sel]);
	end

	// master keeps the request up until the ack
	a_ack_in_request: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb));

endmodule

// ==== logic/delay_ring_top.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module delay_ring_top import drbe_pkg::*; (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               in_valid,
	input  sample_t            in_sample,
	input  logic               scenario_update,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [`WB_AW-1:0]  wb_adr,
	input  logic [`WB_DW-1:0]  wb_dat_w,
	output logic [`WB_DW-1:0]  wb_dat_r,
	output logic               wb_ack,
	output logic [`N_CTRL-1:0] pkt_valid,
	output sample_t            pkt_sample [`N_CTRL],
	output dest_t              pkt_dest [`N_CTRL]
);

	delay_t             delay [`N_CTRL];
	dest_t              dest [`N_CTRL];
	// token[n] is driven by node n
	logic [`N_CTRL-1:0] token;

	cfg_regs cfg_regs_inst (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.wb_cyc          (wb_cyc),
		.wb_stb          (wb_stb),
		.wb_we           (wb_we),
		.wb_adr          (wb_adr),
		.wb_dat_w        (wb_dat_w),
		.wb_dat_r        (wb_dat_r),
		.wb_ack          (wb_ack),
		.scenario_update (scenario_update),
		.delay           (delay),
		.dest            (dest)
	);

	////////////////////////////////////////////////////////////
	// ring of local controllers, last node feeds node 0
	////////////////////////////////////////////////////////////
	for (genvar n = 0; n < `N_CTRL; n++) begin : g_node
		local_controller #(
			.node_index(n)
		) local_controller_inst (
			.CLK        (CLK),
			.rst_n      (rst_n),
			.in_valid   (in_valid),
			.in_sample  (in_sample),
			.token_in   (token[(n + `N_CTRL - 1) % `N_CTRL]),
			.delay      (delay[n]),
			.dest       (dest[n]),
			.token_next (token[n]),
			.pkt_valid  (pkt_valid[n]),
			.pkt_sample (pkt_sample[n]),
			.pkt_dest   (pkt_dest[n])
		);
	end

endmodule

// ==== logic/drbe_defs.svh ====
`ifndef DRBE_DEFS_SVH
`define DRBE_DEFS_SVH

// ring geometry
`define N_CTRL    4
`define SEG_LEN   8

// complex sample, one component
`define SAMPLE_W  16

// local circular buffer
`define BUF_DEPTH 64
`define BUF_AW    6

// configuration path
`define DEST_W    4
`define WB_AW     3
`define WB_DW     16

`endif

// ==== logic/drbe_pkg.sv ====
`include "drbe_defs.svh"

package drbe_pkg;

	// complex sample, I in the upper half
	typedef struct packed {
		logic [`SAMPLE_W-1:0] i;
		logic [`SAMPLE_W-1:0] q;
	} sample_t;

	// address into one local buffer
	typedef logic [`BUF_AW-1:0] buf_addr_t;

	// echo delay in local writes
	// 0 keeps the node silent, must stay below BUF_DEPTH
	typedef logic [`BUF_AW-1:0] delay_t;

	// destination tag carried by each echo packet
	typedef logic [`DEST_W-1:0] dest_t;

endpackage

// ==== logic/echo_packet_reader.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module echo_packet_reader import drbe_pkg::*; (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             wr_en,
	input  buf_addr_t        wr_addr,
	input  logic [`BUF_AW:0] wr_count,
	input  delay_t           delay,
	input  dest_t            dest,
	output logic             rd_en,
	output buf_addr_t        rd_addr,
	input  sample_t          rd_data,
	output logic             pkt_valid,
	output sample_t          pkt_sample,
	output dest_t            pkt_dest
);

	logic  rd_pend;
	dest_t dest_pend;

	////////////////////////////////////////////////////////////
	// echo read issue
	////////////////////////////////////////////////////////////

	// silent for delay 0 or while history is too short
	assign rd_en = wr_en && (delay != '0) && (wr_count >= {1'b0, delay});
	// modulo wrap of the circular buffer
	assign rd_addr = wr_addr - delay;

	////////////////////////////////////////////////////////////
	// packet pipeline, valid and tag follow the buffer read
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			rd_pend <= 1'b0;
			pkt_valid <= 1'b0;
		end else begin
			rd_pend <= rd_en;
			pkt_valid <= rd_pend;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_en)
			dest_pend <= dest;
		if (rd_pend) begin
			pkt_sample <= rd_data;
			pkt_dest <= dest_pend;
		end
	end

endmodule

// ==== logic/local_controller.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module local_controller import drbe_pkg::*; #(
	parameter int node_index = 0
) (
	input  logic    CLK,
	input  logic    rst_n,
	input  logic    in_valid,
	input  sample_t in_sample,
	input  logic    token_in,
	input  delay_t  delay,
	input  dest_t   dest,
	output logic    token_next,
	output logic    pkt_valid,
	output sample_t pkt_sample,
	output dest_t   pkt_dest
);

	logic             wr_en;
	buf_addr_t        wr_addr;
	sample_t          wr_data;
	logic [`BUF_AW:0] wr_count;
	logic             rd_en;
	buf_addr_t        rd_addr;
	sample_t          rd_data;

	// producer side, token and write pointer
	sample_writer #(
		.node_index(node_index)
	) sample_writer_inst (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.token_in   (token_in),
		.token_next (token_next),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_count   (wr_count)
	);

	sample_ring_buffer #(
		.payload_t(sample_t)
	) sample_ring_buffer_inst (
		.CLK     (CLK),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_en   (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// consumer side, one echo per stored sample
	echo_packet_reader echo_packet_reader_inst (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_count   (wr_count),
		.delay      (delay),
		.dest       (dest),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.pkt_valid  (pkt_valid),
		.pkt_sample (pkt_sample),
		.pkt_dest   (pkt_dest)
	);

endmodule

// ==== logic/sample_ring_buffer.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module sample_ring_buffer import drbe_pkg::*; #(
	parameter type payload_t = logic [31:0]
) (
	input  logic      CLK,
	input  logic      wr_en,
	input  buf_addr_t wr_addr,
	input  payload_t  wr_data,
	input  logic      rd_en,
	input  buf_addr_t rd_addr,
	output payload_t  rd_data
);

	payload_t mem [`BUF_DEPTH];

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read port
	always_ff @(posedge CLK) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	// a nonzero delay keeps the echo read off the write slot
	a_no_collision: assert property (@(posedge CLK)
		(wr_en && rd_en) |-> (wr_addr != rd_addr));

endmodule

// ==== logic/sample_writer.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module sample_writer import drbe_pkg::*; #(
	parameter int node_index = 0
) (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             in_valid,
	input  sample_t          in_sample,
	input  logic             token_in,
	output logic             token_next,
	output logic             wr_en,
	output buf_addr_t        wr_addr,
	output sample_t          wr_data,
	output logic [`BUF_AW:0] wr_count
);

	localparam int SEG_W = $clog2(`SEG_LEN);
	localparam int CNT_W = `BUF_AW + 1;

	logic             held;
	logic             owns;
	logic             seg_last;
	logic [SEG_W-1:0] seg_cnt;
	buf_addr_t        wr_ptr;

	// token arriving this cycle already counts as owned
	assign owns = held | token_in;
	assign wr_en = in_valid & owns;
	assign seg_last = (seg_cnt == SEG_W'(`SEG_LEN - 1));
	assign wr_addr = wr_ptr;
	assign wr_data = in_sample;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			held <= (node_index == 0);
			token_next <= 1'b0;
			seg_cnt <= '0;
			wr_ptr <= '0;
			wr_count <= '0;
		end else begin
			// last sample of the segment hands the token on
			token_next <= wr_en & seg_last;
			held <= owns & ~(wr_en & seg_last);
			if (wr_en) begin
				seg_cnt <= seg_last ? '0 : seg_cnt + 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
				// saturates at the depth since every delay lies below it
				if (wr_count != CNT_W'(`BUF_DEPTH))
					wr_count <= wr_count + 1'b1;
			end
		end
	end

	// only one token travels the ring
	a_single_token: assert property (@(posedge CLK) disable iff (!rst_n)
		token_in |-> !held);

endmodule

// ==== tests/delay_ring_checker.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module delay_ring_checker import drbe_pkg::*; (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               in_valid,
	input  sample_t            in_sample,
	input  logic               scenario_update,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [`WB_AW-1:0]  wb_adr,
	input  logic [`WB_DW-1:0]  wb_dat_w,
	input  logic [`WB_DW-1:0]  wb_dat_r,
	input  logic               wb_ack,
	input  logic [`N_CTRL-1:0] pkt_valid,
	input  sample_t            pkt_sample [`N_CTRL],
	input  dest_t              pkt_dest [`N_CTRL],
	output int                 err_count,
	output int                 pkt_count,
	output int                 ack_count
);

	// global accepted samples since reset
	int      total;
	int      wcount [`N_CTRL];
	sample_t hist [`N_CTRL][`BUF_DEPTH];
	int      sh_delay [`N_CTRL];
	int      sh_dest [`N_CTRL];
	int      act_delay [`N_CTRL];
	int      act_dest [`N_CTRL];
	// expected packet pipe where stage 1 is due at the current edge
	logic    exp_v [2];
	int      exp_node [2];
	sample_t exp_sample [2];
	dest_t   exp_dest [2];

	initial begin
		err_count = 0;
		pkt_count = 0;
		ack_count = 0;
	end

	task automatic compare_packets();
		logic want;
		for (int n = 0; n < `N_CTRL; n++) begin
			want = exp_v[1] && (exp_node[1] == n);
			if (want && !pkt_valid[n]) begin
				$display("node %0d did not send its expected echo packet at %0t ns", n, $time);
				err_count++;
			end else if (!want && pkt_valid[n] === 1'b1) begin
				$display("node %0d sent an echo packet that was not expected at %0t ns",
					n, $time);
				err_count++;
			end else if (want) begin
				pkt_count++;
				if (pkt_sample[n] !== exp_sample[1] || pkt_dest[n] !== exp_dest[1]) begin
					$display("error %0t ns: node %0d packet %h dest %0d, expected %h dest %0d",
						$time, n, pkt_sample[n], pkt_dest[n], exp_sample[1], exp_dest[1]);
					err_count++;
				end
			end
		end
	endtask

	always @(posedge CLK) begin
		int node;
		int cnt;
		if (!rst_n) begin
			total = 0;
			exp_v[0] = 1'b0;
			exp_v[1] = 1'b0;
			for (int n = 0; n < `N_CTRL; n++) begin
				wcount[n] = 0;
				sh_delay[n] = 0;
				sh_dest[n] = 0;
				act_delay[n] = 0;
				act_dest[n] = 0;
			end
		end else begin
			compare_packets();
			exp_v[1] = exp_v[0];
			exp_node[1] = exp_node[0];
			exp_sample[1] = exp_sample[0];
			exp_dest[1] = exp_dest[0];
			exp_v[0] = 1'b0;

			////////////////////////////////////////////////////////////
			// segment k goes to node k mod N_CTRL
			////////////////////////////////////////////////////////////
			if (in_valid) begin
				node = (total / `SEG_LEN) % `N_CTRL;
				cnt = wcount[node];
				if (act_delay[node] >= 1 && cnt >= act_delay[node]) begin
					exp_v[0] = 1'b1;
					exp_node[0] = node;
					exp_sample[0] = hist[node][(cnt - act_delay[node]) % `BUF_DEPTH];
					exp_dest[0] = dest_t'(act_dest[node]);
				end
				hist[node][cnt % `BUF_DEPTH] = in_sample;
				wcount[node] = cnt + 1;
				total++;
			end

			// active copy sees the shadow from before this edge
			if (scenario_update) begin
				for (int n = 0; n < `N_CTRL; n++) begin
					act_delay[n] = sh_delay[n];
					act_dest[n] = sh_dest[n];
				end
			end

			if (wb_ack) begin
				ack_count++;
				node = int'(wb_adr[2:1]);
				if (!(wb_cyc && wb_stb)) begin
					$display("Wishbone ack arrived with no request on the bus at %0t ns",
						$time);
					err_count++;
				end
				if (wb_we && wb_adr[0])
					sh_dest[node] = int'(wb_dat_w);
				else if (wb_we)
					sh_delay[node] = int'(wb_dat_w);
				else if (int'(wb_dat_r) != (wb_adr[0] ? sh_dest[node] : sh_delay[node])) begin
					$display("error %0t ns: readback node %0d field %0d is %0d", $time, node,
						wb_adr[0], wb_dat_r);
					err_count++;
				end
			end
		end
	end

endmodule

// ==== tests/delay_ring_tb.sv ====
`timescale 1ns/100ps
`include "drbe_defs.svh"

module delay_ring_tb import drbe_pkg::*; ();

	// test lengths in clock cycles
	localparam int LEN_CFG = 100;
	localparam int LEN_TOKEN = 400;
	localparam int LEN_RAND = 1000;
	localparam int LEN_SHADOW = 600;
	localparam int LEN_WRAP = 900;
	// bus programming and drain around each stream
	localparam int SLACK = 150;
	localparam int LIMIT_NS = (LEN_CFG + LEN_TOKEN + LEN_RAND + LEN_SHADOW + LEN_WRAP
		+ 5 * SLACK) * 4 * 2;

	logic               CLK;
	logic               rst_n;
	logic               in_valid;
	sample_t            in_sample;
	logic               scenario_update;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic [`WB_AW-1:0]  wb_adr;
	logic [`WB_DW-1:0]  wb_dat_w;
	logic [`WB_DW-1:0]  wb_dat_r;
	logic               wb_ack;
	logic [`N_CTRL-1:0] pkt_valid;
	sample_t            pkt_sample [`N_CTRL];
	dest_t              pkt_dest [`N_CTRL];
	int                 err_count;
	int                 pkt_count;
	int                 ack_count;
	int                 tb_errors = 0;
	int                 req_count = 0;
	int                 err_base;
	int                 pkt_base;
	logic [31:0]        seed = 32'ha90a;

	delay_ring_top delay_ring_top_inst (.*);

	delay_ring_checker delay_ring_checker_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		#(LIMIT_NS);
		$display("watchdog expired before all tests finished");
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
	endfunction

	////////////////////////////////////////////////////////////
	// Wishbone master, one request per call
	////////////////////////////////////////////////////////////
	task automatic wb_access(input logic we, input int node, input logic field,
			input int value);
		int waited;
		waited = 0;
		@(posedge CLK);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= {node[1:0], field};
		wb_dat_w <= value[`WB_DW-1:0];
		req_count++;
		do begin
			@(posedge CLK);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			$display("no Wishbone ack for node %0d field %0d within 16 cycles", node, field);
			tb_errors++;
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic configure(input int node, input int dly, input int dst);
		wb_access(1'b1, node, 1'b0, dly);
		wb_access(1'b1, node, 1'b1, dst);
	endtask

	task automatic pulse_update();
		@(posedge CLK);
		scenario_update <= 1'b1;
		@(posedge CLK);
		scenario_update <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge CLK);
		rst_n <= 1'b0;
		repeat (4) @(posedge CLK);
		rst_n <= 1'b1;
	endtask

	// random samples, gap_pct percent of cycles left idle
	task automatic run_stream(input int cycles, input int gap_pct);
		for (int c = 0; c < cycles; c++) begin
			@(posedge CLK);
			in_valid <= (rand_range(0, 99) >= gap_pct);
			in_sample <= lcg_next();
		end
		@(posedge CLK);
		in_valid <= 1'b0;
		repeat (4) @(posedge CLK);
	endtask

	task automatic mark_start();
		err_base = tb_errors + err_count;
		pkt_base = pkt_count;
	endtask

	task automatic report_test(input string name, input bit need_pkts);
		if (need_pkts && pkt_count == pkt_base) begin
			$display("%s: no echo packets were seen", name);
			tb_errors++;
		end
		$display("%s: %0d packets, %0d errors", name, pkt_count - pkt_base,
			tb_errors + err_count - err_base);
	endtask

	initial begin
		int d;
		int t;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sample = '0;
		scenario_update = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (4) @(posedge CLK);
		rst_n <= 1'b1;

		mark_start();
		for (int r = 0; r < 2 * `N_CTRL; r++)
			wb_access(1'b1, r / 2, r[0],
				r[0] ? rand_range(0, (1 << `DEST_W) - 1) : rand_range(0, `BUF_DEPTH - 1));
		for (int r = 0; r < 2 * `N_CTRL; r++)
			wb_access(1'b0, r / 2, r[0], 0);
		repeat (2) @(posedge CLK);
		if (ack_count != req_count) begin
			$display("%0d Wishbone acks seen for %0d requests", ack_count, req_count);
			tb_errors++;
		end
		report_test("config round trip", 1'b0);

		// every node echoes its previous local sample
		mark_start();
		for (int n = 0; n < `N_CTRL; n++)
			configure(n, 1, rand_range(0, 15));
		pulse_update();
		run_stream(LEN_TOKEN, 0);
		report_test("token distribution", 1'b1);

		// last node silent
		mark_start();
		for (int n = 0; n < `N_CTRL; n++) begin
			d = (n == `N_CTRL - 1) ? 0 : rand_range(1, 40);
			t = rand_range(0, 15);
			configure(n, d, t);
		end
		pulse_update();
		run_stream(LEN_RAND, 25);
		report_test("random delays with gaps", 1'b1);

		// new shadows stay hidden until the pulse in mid stream
		mark_start();
		for (int n = 0; n < `N_CTRL; n++) begin
			d = rand_range(1, 40);
			t = rand_range(0, 15);
			configure(n, d, t);
		end
		run_stream(LEN_SHADOW / 2, 10);
		fork
			run_stream(LEN_SHADOW / 2, 10);
			begin
				repeat (LEN_SHADOW / 4) @(posedge CLK);
				pulse_update();
			end
		join
		report_test("shadow isolation and update", 1'b1);

		// fresh history, long delays, pointer wraps several times
		mark_start();
		apply_reset();
		for (int n = 0; n < `N_CTRL; n++) begin
			d = rand_range(20, 40);
			t = rand_range(0, 15);
			configure(n, d, t);
		end
		pulse_update();
		run_stream(LEN_WRAP, 10);
		report_test("history and wrap", 1'b1);

		$display("%0d packets checked, %0d errors", pkt_count, tb_errors + err_count);
		if (tb_errors + err_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/drbe_pkg.sv
logic/cfg_regs.sv
logic/sample_writer.sv
logic/sample_ring_buffer.sv
logic/echo_packet_reader.sv
logic/local_controller.sv
logic/delay_ring_top.sv
tests/delay_ring_checker.sv
tests/delay_ring_tb.sv
